//--- Bender.yml
package:
  name: board_audio_meter

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/board_pkg.sv
      - rtl/i2s_mic_receiver.sv
      - rtl/key_debouncer.sv
      - rtl/level_display.sv
      - rtl/board_audio_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/board_audio_properties.sv
      - verif/tb_board_audio_top.sv

//--- rtl/board_audio_top.sv
// Board audio meter top
// Microphone receiver and key debouncer feeding the level display

`timescale 1ns/1ps

`include "board_params.svh"

module board_audio_top
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [`W_KEY   - 1:0] key,
    input  logic                  mic_sd,
    output logic                  mic_sck,
    output logic                  mic_ws,
    output logic [`W_LED   - 1:0] led,
    output board_pkg::seg_t       hgfedcba,
    output logic [`W_DIGIT - 1:0] digit
);

    import board_pkg::*;

    mic_sample_t         mic_sample;
    logic                sample_valid;
    logic [`W_KEY - 1:0] key_press;

    //------------------------------------------------

    i2s_mic_receiver i_microphone
    (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .mic_sd       ( mic_sd       ),
        .mic_sck      ( mic_sck      ),
        .mic_ws       ( mic_ws       ),
        .mic_sample   ( mic_sample   ),
        .sample_valid ( sample_valid )
    );

    // Only the press pulses drive the display
    key_debouncer i_keys
    (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .key          ( key          ),
        .key_level    (              ),
        .key_press    ( key_press    )
    );

    level_display i_display
    (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .mic_sample   ( mic_sample   ),
        .sample_valid ( sample_valid ),
        .key_press    ( key_press    ),
        .led          ( led          ),
        .hgfedcba     ( hgfedcba     ),
        .digit        ( digit        )
    );

endmodule

//--- rtl/board_params.svh
// Board audio meter build constants
// Serial clock division, I2S frame shape, debounce time and I/O widths

`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// I2S microphone frame
`define SCK_HALF        4
`define SLOT_BITS       32
`define SAMPLE_BITS     24

// Keys, sized for simulation
`define DEBOUNCE_CYCLES 16
`define W_KEY           2

// LED bar and seven-segment readout
`define W_LED           8
`define W_DIGIT         2
`define DIGIT_CYCLES    8

`endif

//--- rtl/board_pkg.sv
// Board audio meter types
// Microphone sample, absolute level and segment vector

`include "board_params.svh"

package board_pkg;

    // Signed sample as delivered by the INMP441
    typedef logic signed [`SAMPLE_BITS - 1:0] mic_sample_t;

    // Absolute level after saturation
    typedef logic        [`SAMPLE_BITS - 1:0] magnitude_t;

    // Segments with the decimal point in the MSB
    typedef logic        [7:0]                seg_t;

    //------------------------------------------------
    // Range limits used by the level logic

    localparam mic_sample_t SAMPLE_MIN    = {1'b1, {(`SAMPLE_BITS - 1){1'b0}}};
    localparam magnitude_t  MAGNITUDE_MAX = {1'b0, {(`SAMPLE_BITS - 1){1'b1}}};

endpackage

//--- rtl/i2s_mic_receiver.sv
// I2S microphone receiver
// Generates serial clock and word select, captures the left slot sample

`timescale 1ns/1ps

`include "board_params.svh"

module i2s_mic_receiver
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   mic_sd,
    output logic                   mic_sck,
    output logic                   mic_ws,
    output board_pkg::mic_sample_t mic_sample,
    output logic                   sample_valid
);

    import board_pkg::*;

    localparam int W_HALF     = $clog2(`SCK_HALF);
    localparam int FRAME_BITS = 2 * `SLOT_BITS;
    localparam int W_BIT      = $clog2(FRAME_BITS);

    logic [W_HALF - 1:0] half_cnt;
    logic                sck_q;
    logic                sck_toggle;
    logic                sck_rise;
    logic                sck_fall;

    logic [W_BIT - 1:0]  bit_cnt;
    logic [W_BIT - 1:0]  bit_cnt_nxt;
    logic                ws_q;

    logic                capture;
    logic                last_bit;
    mic_sample_t         shift_q;

    //------------------------------------------------
    // Serial clock divider

    assign sck_toggle = (half_cnt == W_HALF'(`SCK_HALF - 1));
    assign sck_rise   = sck_toggle & ~sck_q;
    assign sck_fall   = sck_toggle &  sck_q;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            half_cnt <= '0;
            sck_q    <= 1'b0;
        end
        else if (sck_toggle)
        begin
            half_cnt <= '0;
            sck_q    <= ~sck_q;
        end
        else
        begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    //------------------------------------------------
    // Frame position, word select moves on falling sck

    assign bit_cnt_nxt = (bit_cnt == W_BIT'(FRAME_BITS - 1)) ? '0 : bit_cnt + 1'b1;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bit_cnt <= '0;
            ws_q    <= 1'b0;
        end
        else if (sck_fall)
        begin
            bit_cnt <= bit_cnt_nxt;
            ws_q    <= (bit_cnt_nxt >= W_BIT'(`SLOT_BITS));
        end
    end

    //------------------------------------------------
    // Left slot capture, one bit delay after ws falls

    assign capture  = sck_rise & ~ws_q & (bit_cnt != '0)
                      & (bit_cnt <= W_BIT'(`SAMPLE_BITS));
    assign last_bit = sck_rise & ~ws_q & (bit_cnt == W_BIT'(`SAMPLE_BITS));

    always_ff @(posedge clk)
    begin
        if (capture)
            shift_q <= {shift_q[`SAMPLE_BITS - 2:0], mic_sd};

        // Bit 0 completes the word
        if (last_bit)
            mic_sample <= {shift_q[`SAMPLE_BITS - 2:0], mic_sd};
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            sample_valid <= 1'b0;
        else
            sample_valid <= last_bit;
    end

    assign mic_sck = sck_q;
    assign mic_ws  = ws_q;

endmodule

//--- rtl/key_debouncer.sv
// Key debouncer
// Two-flop synchronizer and stability counter per key, press pulse on rise

`timescale 1ns/1ps

`include "board_params.svh"

module key_debouncer
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic [`W_KEY - 1:0] key,
    output logic [`W_KEY - 1:0] key_level,
    output logic [`W_KEY - 1:0] key_press
);

    localparam int W_CNT = $clog2(`DEBOUNCE_CYCLES);

    logic [`W_KEY - 1:0] sync_0;
    logic [`W_KEY - 1:0] sync_1;
    logic [W_CNT - 1:0]  stable_cnt [`W_KEY];

    //------------------------------------------------
    // Synchronizer

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync_0 <= '0;
            sync_1 <= '0;
        end
        else
        begin
            sync_0 <= key;
            sync_1 <= sync_0;
        end
    end

    //------------------------------------------------
    // Stability counters and accepted levels

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            key_level <= '0;
            key_press <= '0;
            for (int i = 0; i < `W_KEY; i++)
                stable_cnt[i] <= '0;
        end
        else
        begin
            key_press <= '0;
            for (int i = 0; i < `W_KEY; i++)
            begin
                // Any return to the accepted level restarts the interval
                if (sync_1[i] == key_level[i])
                begin
                    stable_cnt[i] <= '0;
                end
                else if (stable_cnt[i] == W_CNT'(`DEBOUNCE_CYCLES - 1))
                begin
                    stable_cnt[i] <= '0;
                    key_level[i]  <= sync_1[i];
                    key_press[i]  <= sync_1[i];
                end
                else
                begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/level_display.sv
// Level display
// Peak and instant level, LED bar and multiplexed hex readout

`timescale 1ns/1ps

`include "board_params.svh"

module level_display
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  board_pkg::mic_sample_t mic_sample,
    input  logic                   sample_valid,
    input  logic [`W_KEY - 1:0]    key_press,
    output logic [`W_LED - 1:0]    led,
    output board_pkg::seg_t        hgfedcba,
    output logic [`W_DIGIT - 1:0]  digit
);

    import board_pkg::*;

    localparam int LED_BASE = `SAMPLE_BITS - `W_LED;
    localparam int HEX_BASE = `SAMPLE_BITS - 4 * `W_DIGIT;
    localparam int W_DCNT   = $clog2(`DIGIT_CYCLES);

    magnitude_t          mag;
    magnitude_t          peak_q;
    magnitude_t          peak_nxt;
    magnitude_t          disp_q;
    magnitude_t          disp_nxt;
    logic                hold_q;
    logic                hold_nxt;
    logic [`W_LED - 1:0] led_nxt;

    logic [W_DCNT - 1:0] dig_cnt;
    logic [3:0]          nibble;
    seg_t                abcdefgh;

    //------------------------------------------------
    // Magnitude with saturation of the most negative code

    always_comb
    begin
        if (mic_sample == SAMPLE_MIN)
            mag = MAGNITUDE_MAX;
        else if (mic_sample[`SAMPLE_BITS - 1])
            mag = magnitude_t'(-mic_sample);
        else
            mag = magnitude_t'(mic_sample);
    end

    // Key 1 clears the peak, key 0 toggles hold
    always_comb
    begin
        hold_nxt = hold_q ^ key_press[0];

        peak_nxt = peak_q;
        if (key_press[1])
            peak_nxt = '0;
        else if (sample_valid && (mag > peak_q))
            peak_nxt = mag;

        disp_nxt = disp_q;
        if (hold_nxt)
            disp_nxt = peak_nxt;
        else if (sample_valid)
            disp_nxt = mag;

        // Thermometer bar from 2^16 upwards
        for (int i = 0; i < `W_LED; i++)
            led_nxt[i] = (disp_nxt >= (magnitude_t'(1) << (LED_BASE + i)));
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            peak_q <= '0;
            disp_q <= '0;
            hold_q <= 1'b0;
            led    <= '0;
        end
        else
        begin
            peak_q <= peak_nxt;
            disp_q <= disp_nxt;
            hold_q <= hold_nxt;
            led    <= led_nxt;
        end
    end

    //------------------------------------------------
    // Digit rotation

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            dig_cnt <= '0;
            digit   <= `W_DIGIT'(1);
        end
        else if (dig_cnt == W_DCNT'(`DIGIT_CYCLES - 1))
        begin
            dig_cnt <= '0;
            digit   <= {digit[`W_DIGIT - 2:0], digit[`W_DIGIT - 1]};
        end
        else
        begin
            dig_cnt <= dig_cnt + 1'b1;
        end
    end

    //------------------------------------------------
    // Hex decoder, a in the MSB before reversal

    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < `W_DIGIT; i++)
            if (digit[i])
                nibble = nibble | disp_q[HEX_BASE + 4 * i +: 4];

        case (nibble)
            4'h0:    abcdefgh = 8'b1111_1100;
            4'h1:    abcdefgh = 8'b0110_0000;
            4'h2:    abcdefgh = 8'b1101_1010;
            4'h3:    abcdefgh = 8'b1111_0010;
            4'h4:    abcdefgh = 8'b0110_0110;
            4'h5:    abcdefgh = 8'b1011_0110;
            4'h6:    abcdefgh = 8'b1011_1110;
            4'h7:    abcdefgh = 8'b1110_0000;
            4'h8:    abcdefgh = 8'b1111_1110;
            4'h9:    abcdefgh = 8'b1111_0110;
            4'ha:    abcdefgh = 8'b1110_1110;
            4'hb:    abcdefgh = 8'b0011_1110;
            4'hc:    abcdefgh = 8'b1001_1100;
            4'hd:    abcdefgh = 8'b0111_1010;
            4'he:    abcdefgh = 8'b1001_1110;
            default: abcdefgh = 8'b1000_1110;
        endcase

        for (int i = 0; i < $bits(seg_t); i++)
            hgfedcba[i] = abcdefgh[$bits(seg_t) - 1 - i];
    end

endmodule

//--- tb.f
+incdir+rtl
rtl/board_pkg.sv
rtl/i2s_mic_receiver.sv
rtl/key_debouncer.sv
rtl/level_display.sv
rtl/board_audio_top.sv
verif/board_audio_properties.sv
verif/tb_board_audio_top.sv

//--- verif/board_audio_properties.sv
// Concurrent checks on microphone framing and display multiplexing
// Bound into the top level where receiver and display signals meet

`timescale 1ns/1ps

`include "board_params.svh"

module board_audio_properties
(
    input logic                  clk,
    input logic                  arst_n,
    input logic                  sample_valid,
    input logic                  mic_sck,
    input logic                  mic_ws,
    input logic [`W_DIGIT - 1:0] digit
);

    // Number of failed assertions
    int failures = 0;

    // Valid is a single clk pulse
    valid_pulse_a: assert property (@(posedge clk) disable iff (!arst_n)
        sample_valid |=> !sample_valid)
        else
        begin
            $error("sample_valid stayed high for more than one cycle");
            failures++;
        end

    // Word select moves only with a falling serial clock
    ws_edge_a: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(mic_ws) |-> $fell(mic_sck))
        else
        begin
            $error("mic_ws changed without a falling mic_sck");
            failures++;
        end

    digit_onehot_a: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot(digit))
        else
        begin
            $error("digit select is not one-hot");
            failures++;
        end

endmodule

bind board_audio_top board_audio_properties u_properties
(
    .clk          ( clk          ),
    .arst_n       ( arst_n       ),
    .sample_valid ( sample_valid ),
    .mic_sck      ( mic_sck      ),
    .mic_ws       ( mic_ws       ),
    .digit        ( digit        )
);

//--- verif/tb_board_audio_top.sv
// Board audio meter testbench
// Microphone and key models, directed level, hold, clear and debounce tests

`timescale 1ns/1ps

`include "board_params.svh"

module tb_board_audio_top;

    import board_pkg::*;

    localparam int FRAME_CYCLES = 4 * `SLOT_BITS * `SCK_HALF;
    localparam int NUM_FRAMES   = 28;
    localparam int KEY_EVENTS   = 6;
    localparam int LED_LSB      = `SAMPLE_BITS - `W_LED;
    localparam int HEX_LSB      = `SAMPLE_BITS - 4 * `W_DIGIT;

    // Standard hex patterns, bit 0 is segment a
    localparam logic [7:0] HEX_SEG [16] = '{
        8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
        8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71};

    localparam mic_sample_t BIG_SAMPLE = 24'ha4f000;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic [`W_KEY - 1:0]   key;
    logic                  mic_sd = 1'b0;
    logic                  mic_sck;
    logic                  mic_ws;
    logic [`W_LED - 1:0]   led;
    seg_t                  hgfedcba;
    logic [`W_DIGIT - 1:0] digit;

    mic_sample_t           frame_sample = '0;
    int                    bit_pos = 0;
    logic                  sck_prev = 1'b0;
    logic                  ws_prev = 1'b0;
    integer                seed;
    int                    errors;
    int                    checks;

    board_audio_top DUT
    (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .key      ( key      ),
        .mic_sd   ( mic_sd   ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .led      ( led      ),
        .hgfedcba ( hgfedcba ),
        .digit    ( digit    )
    );

    always #50 clk = ~clk;

    //--------------------------------------------------
    // Microphone model, next bit after each falling sck

    always @(negedge clk)
    begin
        if (!arst_n)
        begin
            bit_pos = 0;
            mic_sd  = 1'b0;
        end
        else if (sck_prev && !mic_sck)
        begin
            // Word select dropping marks the start of the left slot
            if (ws_prev && !mic_ws)
                bit_pos = 0;
            else
                bit_pos = bit_pos + 1;
            if (!mic_ws && bit_pos >= 1 && bit_pos <= `SAMPLE_BITS)
                mic_sd = frame_sample[`SAMPLE_BITS - bit_pos];
            else
                mic_sd = 1'b0;
        end
        sck_prev = mic_sck;
        ws_prev  = mic_ws;
    end

    //--------------------------------------------------
    // Reference rules

    function automatic magnitude_t magnitude_of(input mic_sample_t value);
        int level;
        level = value;
        if (level < 0)
            level = -level;
        if (level > (1 << (`SAMPLE_BITS - 1)) - 1)
            level = (1 << (`SAMPLE_BITS - 1)) - 1;
        return magnitude_t'(level);
    endfunction

    function automatic logic [`W_LED - 1:0] led_for(input magnitude_t value);
        logic [`W_LED - 1:0] bar;
        for (int i = 0; i < `W_LED; i++)
            bar[i] = |(value >> (LED_LSB + i));
        return bar;
    endfunction

    //--------------------------------------------------
    // Stimulus and checking tasks

    task automatic send_sample(input mic_sample_t value);
        while (mic_ws !== 1'b1)
            @(negedge clk);
        frame_sample = value;
        while (mic_ws !== 1'b0)
            @(negedge clk);
        while (mic_ws !== 1'b1)
            @(negedge clk);
        // Silence in later frames
        frame_sample = '0;
    endtask

    task automatic press_key(input int idx, input int hold_cycles);
        key[idx] = 1'b1;
        repeat (hold_cycles) @(negedge clk);
        key[idx] = 1'b0;
        repeat (3 * `DEBOUNCE_CYCLES) @(negedge clk);
    endtask

    task automatic check_display(input string name, input magnitude_t value);
        logic [`W_LED - 1:0] exp_led;
        logic [7:0]          exp_seg;
        int                  waited;
        exp_led = led_for(value);
        checks++;
        if (led !== exp_led)
        begin
            errors++;
            $display("Fail %s led: expected %h, actual %h", name, exp_led, led);
        end
        for (int d = 0; d < `W_DIGIT; d++)
        begin
            waited = 0;
            while (digit !== (`W_DIGIT'(1) << d) && waited < 2 * `W_DIGIT * `DIGIT_CYCLES)
            begin
                @(negedge clk);
                waited++;
            end
            exp_seg = HEX_SEG[value[HEX_LSB + 4 * d +: 4]];
            checks++;
            if (digit !== (`W_DIGIT'(1) << d))
            begin
                errors++;
                $display("Digit %0d was never selected during %s", d, name);
            end
            else if (hgfedcba !== exp_seg)
            begin
                errors++;
                $display("Fail %s digit %0d: expected %h, actual %h", name, d, exp_seg,
                         hgfedcba);
            end
        end
    endtask

    //--------------------------------------------------
    // Directed tests

    task automatic run_reset_test();
        checks++;
        if (digit !== `W_DIGIT'(1) || mic_sck !== 1'b0 || mic_ws !== 1'b0)
        begin
            errors++;
            $display("Fail reset outputs: expected 1/0/0, actual %h/%b/%b", digit, mic_sck,
                     mic_ws);
        end
        check_display("reset", '0);
    endtask

    task automatic run_instant_test();
        logic [31:0] rnd;
        mic_sample_t value;
        for (int n = 0; n < 20; n++)
        begin
            rnd   = $random(seed);
            value = $signed(rnd[`SAMPLE_BITS - 1:0]) >>> rnd[31:28];
            // Most negative code saturates
            if (n == 7)
                value = {1'b1, {(`SAMPLE_BITS - 1){1'b0}}};
            send_sample(value);
            check_display($sformatf("instant %0d", n), magnitude_of(value));
        end
    endtask

    task automatic run_hold_test();
        press_key(1, 3 * `DEBOUNCE_CYCLES);
        press_key(0, 3 * `DEBOUNCE_CYCLES);
        send_sample(BIG_SAMPLE);
        check_display("hold peak", magnitude_of(BIG_SAMPLE));
        send_sample(24'h001200);
        check_display("hold small 0", magnitude_of(BIG_SAMPLE));
        send_sample(-24'sh030000);
        check_display("hold small 1", magnitude_of(BIG_SAMPLE));
        send_sample(24'h10ffff);
        check_display("hold small 2", magnitude_of(BIG_SAMPLE));
        press_key(0, 3 * `DEBOUNCE_CYCLES);
        send_sample(24'h2c0000);
        check_display("hold released", magnitude_of(24'h2c0000));
    endtask

    task automatic run_clear_test();
        press_key(0, 3 * `DEBOUNCE_CYCLES);
        check_display("clear before", magnitude_of(BIG_SAMPLE));
        press_key(1, 3 * `DEBOUNCE_CYCLES);
        check_display("clear after", '0);
        send_sample(24'h3f8000);
        check_display("clear new peak", magnitude_of(24'h3f8000));
    endtask

    task automatic run_debounce_test();
        press_key(0, `DEBOUNCE_CYCLES / 2);
        send_sample(24'h051111);
        check_display("glitch 0", magnitude_of(24'h3f8000));
        send_sample(-24'sh100000);
        check_display("glitch 1", magnitude_of(24'h3f8000));
    endtask

    initial
    begin
        arst_n = 1'b0;
        key    = '0;
        seed   = 16111;
        errors = 0;
        checks = 0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        run_reset_test();
        run_instant_test();
        run_hold_test();
        run_clear_test();
        run_debounce_test();
        // Bound assertion failures count as errors too
        errors = errors + DUT.u_properties.failures;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // Watchdog sized from frames, key presses and reset
    initial
    begin
        repeat (16 + (NUM_FRAMES + 10) * FRAME_CYCLES + KEY_EVENTS * 6 * `DEBOUNCE_CYCLES)
            @(posedge clk);
        $display("Timeout: the tests did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
